/* hw/decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// instruction and data word width
`define DATA_W 16

// ALU select codes
`define ALU_ADD 4'b0000
`define ALU_SUB 4'b0001
`define ALU_AND 4'b0010
`define ALU_OR  4'b0011
`define ALU_XOR 4'b0100
`define ALU_SLL 4'b1000
`define ALU_SLR 4'b1001
`define ALU_SRL 4'b1010
`define ALU_SRA 4'b1011
`define ALU_IDT 4'b1100
`define ALU_NON 4'b1111

// arithmetic format, op3 1110, no write and no forwarding
`define NOP_WORD 16'b11_000_000_1110_0000

// words replaced after a pc load
`define SQUASH_SLOTS 2

`endif

/* hw/decodePkg.sv */
`include "decode_settings.svh"

package decodePkg;

   // register-register format
   typedef struct packed {
      logic [1:0] op;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [3:0] op3;
      logic [3:0] d;
   } arithFields;

   // immediate and branch format
   typedef struct packed {
      logic [1:0]         op;
      logic [2:0]         op2;
      logic [2:0]         rb;
      logic [`DATA_W-9:0] d8;
   } immFields;

   typedef union packed {
      arithFields arith;
      immFields   imm;
   } instrWord;

endpackage

/* hw/decodeCtrlIf.sv */
interface decodeCtrlIf;
   logic [3:0] aluSel;
   logic [2:0] writeAddress;
   logic [2:0] cond;
   logic [2:0] op2;
   logic writeEnable, regWrite, pcLoad, inputMux, adrMux, arMux, brMux;
   logic abMux, mwMux, madMux, spcMux, spSw, spWrite, inc, dec;
   logic flagWrite, signEx, outStrobe, halt;
   // forwarding from one or two words back
   logic oneA, oneB, twoA, twoB;

   modport source (
      output aluSel, writeAddress, cond, op2,
      output writeEnable, regWrite, pcLoad, inputMux, adrMux, arMux, brMux,
      output abMux, mwMux, madMux, spcMux, spSw, spWrite, inc, dec,
      output flagWrite, signEx, outStrobe, halt,
      output oneA, oneB, twoA, twoB
   );

   // issue control only needs the flow-changing bits
   modport sink (
      input pcLoad,
      input halt
   );
endinterface

/* hw/commandHistory.sv */
`include "decode_settings.svh"

module commandHistory (
   input  logic               clk,
   input  logic               rstN,
   input  logic               shift,
   input  logic               squash,
   input  logic [`DATA_W-1:0] instr,
   output decodePkg::instrWord command,
   output decodePkg::instrWord beforeCommand,
   output decodePkg::instrWord twoBeforeCommand
);

   logic [`DATA_W-1:0] nextWord;

   // squashed slots enter as nop
   assign nextWord = squash ? `NOP_WORD : instr;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         command          <= `NOP_WORD;
         beforeCommand    <= `NOP_WORD;
         twoBeforeCommand <= `NOP_WORD;
      end else if (shift) begin
         twoBeforeCommand <= beforeCommand;
         beforeCommand    <= command;
         command          <= nextWord;
      end
   end

endmodule

/* hw/decodeUnit.sv */
`include "decode_settings.svh"

module decodeUnit (
   input decodePkg::instrWord command,
   input decodePkg::instrWord beforeCommand,
   input decodePkg::instrWord twoBeforeCommand,
   decodeCtrlIf.source ctrl
);

   logic [1:0] op;
   logic [3:0] op3;
   logic [4:0] top5;
   logic [7:0] top8;
   logic       isArith;
   logic       consumesA;
   logic       consumesB;

   // producer of a value read through the A port
   function automatic logic producesA(decodePkg::instrWord w);
      return w.arith.op == 2'b11 && w.arith.op3 <= 4'b1100 &&
             w.arith.op3 != 4'b0101 && w.arith.op3 != 4'b0111;
   endfunction

   // B side also sees ADDI results
   function automatic logic producesB(decodePkg::instrWord w);
      return producesA(w) || {w.imm.op, w.imm.op2} == 5'b10001;
   endfunction

   assign op      = command.arith.op;
   assign op3     = command.arith.op3;
   assign top5    = {command.imm.op, command.imm.op2};
   assign top8    = {command.imm.op, command.imm.op2, command.imm.rb};
   assign isArith = op == 2'b11;

   assign consumesA = (isArith && (op3 <= 4'b0110 || op3 == 4'b1101)) || op == 2'b01;
   assign consumesB = (isArith && (op3 <= 4'b0101 || (op3 >= 4'b1000 && op3 <= 4'b1011))) ||
                      op == 2'b00 || op == 2'b01;

   // A compares against the producer's rs slot, B against rb
   assign ctrl.oneA = producesA(beforeCommand) && consumesA &&
                      command.imm.rb == beforeCommand.arith.rs;
   assign ctrl.twoA = producesA(twoBeforeCommand) && consumesA &&
                      command.imm.rb == twoBeforeCommand.arith.rs;
   assign ctrl.oneB = producesB(beforeCommand) && consumesB &&
                      command.imm.rb == beforeCommand.imm.rb;
   assign ctrl.twoB = producesB(twoBeforeCommand) && consumesB &&
                      command.imm.rb == twoBeforeCommand.imm.rb;

   // LD uses the rs position as its destination
   assign ctrl.writeAddress = (op == 2'b00) ? command.arith.rs : command.arith.rd;
   assign ctrl.cond         = command.imm.rb;
   assign ctrl.op2          = command.imm.op2;

   assign ctrl.regWrite = (isArith && op3 <= 4'b1100 && op3 != 4'b0101) ||
                          op == 2'b00 ||
                          top5[4:1] == 4'b1000 ||
                          top5 == 5'b10101;

   assign ctrl.writeEnable = op == 2'b01 || top5 == 5'b10010 || top5 == 5'b10110 ||
                             top8 == 8'b10111110;

   assign ctrl.flagWrite = (isArith && op3 <= 4'b1011 && op3 != 4'b0111) ||
                           top5 == 5'b10001;

   assign ctrl.pcLoad = top5 == 5'b10100 || top5 == 5'b10111;

   assign ctrl.adrMux = (isArith && op3 <= 4'b1011) ||
                        (op == 2'b10 && command.imm.op2 <= 3'b100) ||
                        (top5 == 5'b10111 && command.imm.rb != 3'b111);

   assign ctrl.inputMux  = isArith && op3 == 4'b1100;
   assign ctrl.outStrobe = isArith && op3 == 4'b1101;
   assign ctrl.halt      = isArith && op3 == 4'b1111;
   assign ctrl.arMux     = isArith && op3 <= 4'b0110;
   assign ctrl.brMux     = isArith || op == 2'b01 || top5 == 5'b10001;
   assign ctrl.abMux     = op == 2'b01;
   assign ctrl.signEx    = !isArith;

   // stack and memory address control
   assign ctrl.spcMux  = top5 == 5'b10011 || top5 == 5'b10101;
   assign ctrl.mwMux   = top8 != 8'b10111110;
   assign ctrl.spSw    = top8 != 8'b10111111;
   assign ctrl.madMux  = !(top5 == 5'b10010 || top8[7:1] == 7'b1011111);
   assign ctrl.inc     = top5 == 5'b10010;
   assign ctrl.dec     = top8 == 8'b10111111;
   assign ctrl.spWrite = top5 == 5'b10011;

   always_comb begin
      if (isArith) begin
         case (op3)
            4'b0000: ctrl.aluSel = `ALU_ADD;
            4'b0001: ctrl.aluSel = `ALU_SUB;
            4'b0010: ctrl.aluSel = `ALU_AND;
            4'b0011: ctrl.aluSel = `ALU_OR;
            4'b0100: ctrl.aluSel = `ALU_XOR;
            // CMP
            4'b0101: ctrl.aluSel = `ALU_SUB;
            // MOV
            4'b0110: ctrl.aluSel = `ALU_IDT;
            4'b1000: ctrl.aluSel = `ALU_SLL;
            4'b1001: ctrl.aluSel = `ALU_SLR;
            4'b1010: ctrl.aluSel = `ALU_SRL;
            4'b1011: ctrl.aluSel = `ALU_SRA;
            4'b1100: ctrl.aluSel = `ALU_IDT;
            4'b1111: ctrl.aluSel = `ALU_NON;
            default: ctrl.aluSel = op3;
         endcase
      end else if (!op[1]) begin
         // LD, ST address add
         ctrl.aluSel = `ALU_ADD;
      end else if (top5 == 5'b10000) begin
         ctrl.aluSel = `ALU_IDT;
      end else if (top5 == 5'b10001 || top5 == 5'b10100 || top5 == 5'b10111) begin
         // ADDI and both branches
         ctrl.aluSel = `ALU_ADD;
      end else if (top5 == 5'b10101 || top5 == 5'b10110) begin
         ctrl.aluSel = `ALU_SUB;
      end else begin
         ctrl.aluSel = `ALU_NON;
      end
   end

endmodule

/* hw/squashTimer.sv */
`include "decode_settings.svh"

module squashTimer (
   input  logic       clk,
   input  logic       rstN,
   input  logic       load,
   input  logic       tick,
   output logic [1:0] count,
   output logic       done
);

   assign done = count == 2'd0;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         count <= 2'd0;
      end else if (load) begin
         // a word taken in the load cycle already uses one slot
         count <= 2'(`SQUASH_SLOTS) - {1'b0, tick};
      end else if (tick && !done) begin
         count <= count - 2'd1;
      end
   end

endmodule

/* hw/issueControl.sv */
module issueControl (
   input  logic      clk,
   input  logic      rstN,
   input  logic      instrValid,
   decodeCtrlIf.sink ctrl,
   input  logic      timerDone,
   output logic      accept,
   output logic      squash,
   output logic      timerLoad,
   output logic      timerTick,
   output logic      decodedValid
);

   localparam logic [1:0] RUN    = 2'd0;
   localparam logic [1:0] SQUASH = 2'd1;
   localparam logic [1:0] HALTED = 2'd2;

   logic [1:0] state;
   logic       branchSeen;
   logic       haltSeen;

   // flow bits only count in the cycle they are valid
   assign branchSeen = state == RUN && decodedValid && ctrl.pcLoad;
   assign haltSeen   = state != HALTED && decodedValid && ctrl.halt;

   assign accept    = state != HALTED && !haltSeen;
   assign squash    = branchSeen || (state == SQUASH && !timerDone);
   assign timerLoad = branchSeen;
   assign timerTick = instrValid && accept && squash;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state        <= RUN;
         decodedValid <= 1'b0;
      end else begin
         decodedValid <= instrValid && accept;
         if (haltSeen)
            state <= HALTED;
         else if (branchSeen)
            state <= SQUASH;
         else if (state == SQUASH && timerDone)
            state <= RUN;
      end
   end

endmodule

/* hw/decodeStage.sv */
`include "decode_settings.svh"

module decodeStage (
   input  logic               clk,
   input  logic               rstN,
   input  logic               instrValid,
   input  logic [`DATA_W-1:0] instr,
   output logic               decodedValid,
   output logic [3:0]         aluSel,
   output logic [2:0]         writeAddress,
   output logic [2:0]         cond,
   output logic [2:0]         op2,
   output logic               writeEnable,
   output logic               regWrite,
   output logic               pcLoad,
   output logic               inputMux,
   output logic               adrMux,
   output logic               arMux,
   output logic               brMux,
   output logic               abMux,
   output logic               mwMux,
   output logic               madMux,
   output logic               spcMux,
   output logic               spSw,
   output logic               spWrite,
   output logic               inc,
   output logic               dec,
   output logic               flagWrite,
   output logic               signEx,
   output logic               outStrobe,
   output logic               halt,
   output logic               oneA,
   output logic               oneB,
   output logic               twoA,
   output logic               twoB
);

   decodePkg::instrWord command;
   decodePkg::instrWord beforeCommand;
   decodePkg::instrWord twoBeforeCommand;

   logic       accept;
   logic       squash;
   logic       shift;
   logic       timerLoad;
   logic       timerTick;
   logic       timerDone;

   decodeCtrlIf ctrlBus ();

   assign shift = instrValid && accept;

   commandHistory commandHistory_i (
      .clk              (clk),
      .rstN             (rstN),
      .shift            (shift),
      .squash           (squash),
      .instr            (instr),
      .command          (command),
      .beforeCommand    (beforeCommand),
      .twoBeforeCommand (twoBeforeCommand)
   );

   decodeUnit decodeUnit_i (
      .command          (command),
      .beforeCommand    (beforeCommand),
      .twoBeforeCommand (twoBeforeCommand),
      .ctrl             (ctrlBus.source)
   );

   issueControl issueControl_i (
      .clk          (clk),
      .rstN         (rstN),
      .instrValid   (instrValid),
      .ctrl         (ctrlBus.sink),
      .timerDone    (timerDone),
      .accept       (accept),
      .squash       (squash),
      .timerLoad    (timerLoad),
      .timerTick    (timerTick),
      .decodedValid (decodedValid)
   );

   squashTimer squashTimer_i (
      .clk   (clk),
      .rstN  (rstN),
      .load  (timerLoad),
      .tick  (timerTick),
      .count (),
      .done  (timerDone)
   );

   assign aluSel       = ctrlBus.aluSel;
   assign writeAddress = ctrlBus.writeAddress;
   assign cond         = ctrlBus.cond;
   assign op2          = ctrlBus.op2;
   assign writeEnable  = ctrlBus.writeEnable;
   assign regWrite     = ctrlBus.regWrite;
   assign pcLoad       = ctrlBus.pcLoad;
   assign inputMux     = ctrlBus.inputMux;
   assign adrMux       = ctrlBus.adrMux;
   assign arMux        = ctrlBus.arMux;
   assign brMux        = ctrlBus.brMux;
   assign abMux        = ctrlBus.abMux;
   assign mwMux        = ctrlBus.mwMux;
   assign madMux       = ctrlBus.madMux;
   assign spcMux       = ctrlBus.spcMux;
   assign spSw         = ctrlBus.spSw;
   assign spWrite      = ctrlBus.spWrite;
   assign inc          = ctrlBus.inc;
   assign dec          = ctrlBus.dec;
   assign flagWrite    = ctrlBus.flagWrite;
   assign signEx       = ctrlBus.signEx;
   assign outStrobe    = ctrlBus.outStrobe;
   assign halt         = ctrlBus.halt;
   assign oneA         = ctrlBus.oneA;
   assign oneB         = ctrlBus.oneB;
   assign twoA         = ctrlBus.twoA;
   assign twoB         = ctrlBus.twoB;

endmodule

/* testbench/decodeStageTb.sv */
module decodeStageTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int FIELDS     = 9;
   localparam int MAX_STEPS  = 48;
   localparam int WAIT_LIMIT = 12;

   logic        clk;
   logic        rstN;
   logic        instrValid;
   logic [15:0] instr;
   logic        decodedValid;
   logic [3:0]  aluSel;
   logic [2:0]  writeAddress, cond, op2;
   logic writeEnable, regWrite, pcLoad, inputMux, adrMux, arMux, brMux, abMux;
   logic mwMux, madMux, spcMux, spSw, spWrite, inc, dec, flagWrite;
   logic signEx, outStrobe, halt, oneA, oneB, twoA, twoB;
   logic [39:0] actualCtrl;

   logic [19:0] patMem [0:FIELDS*MAX_STEPS-1];
   string       testNames [0:5] = '{"decode", "fwd one", "fwd two", "squash", "halt", "reset"};
   int          errors = 0;

   decodeStage decodeStage_i (.*);

   // same nibble layout as the pattern file
   assign actualCtrl = {aluSel, 1'b0, writeAddress, 1'b0, cond, 1'b0, op2,
                        writeEnable, regWrite, pcLoad, inputMux,
                        adrMux, arMux, brMux, abMux,
                        mwMux, madMux, spcMux, spSw,
                        spWrite, inc, dec, flagWrite,
                        signEx, outStrobe, halt, 1'b0,
                        oneA, oneB, twoA, twoB};

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic applyReset();
      @(posedge clk);
      #2;
      rstN = 1'b0;
      instrValid = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      rstN = 1'b1;
   endtask

   task automatic strobeWord(input logic [15:0] word);
      @(posedge clk);
      #2;
      instr = word;
      instrValid = 1'b1;
      @(posedge clk);
      #2;
      instrValid = 1'b0;
   endtask

   // sample on the falling edge, away from register updates
   task automatic waitDecoded(output logic seen);
      int cycles;
      seen = 1'b0;
      cycles = 0;
      while (!seen && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         seen = decodedValid;
         cycles++;
      end
   endtask

   task automatic checkValue(input string name, input logic [39:0] expected,
                             input logic [39:0] actual);
      assert (actual === expected)
      else begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   initial begin
      int          a;
      int          step;
      int          base;
      int          group;
      int          passed;
      int          errorsBefore;
      logic        seen;
      logic [39:0] expected;
      string       name;

      rstN = 1'b0;
      instrValid = 1'b0;
      instr = '0;
      void'($urandom(32'h521));
      for (a = 0; a < FIELDS * MAX_STEPS; a++) begin
         patMem[a] = 20'hA5000 ^ 20'(a);
      end
      $readmemh("testbench/decodePatterns.mem", patMem);
      applyReset();
      step = 0;
      passed = 0;
      while (step < MAX_STEPS && patMem[step * FIELDS] <= 20'd5) begin
         base = step * FIELDS;
         group = int'(patMem[base]);
         name = $sformatf("%s #%0d", testNames[group], step);
         errorsBefore = errors;
         if (group == 5)
            applyReset();
         repeat ($urandom % 4) @(posedge clk);
         strobeWord(patMem[base+1][15:0]);
         waitDecoded(seen);
         if (patMem[base+2][0]) begin
            assert (seen)
            else begin
               $display("%s: no decoded output within %0d cycles", name, WAIT_LIMIT);
               errors++;
            end
            if (seen) begin
               expected = {patMem[base+3][3:0], patMem[base+4][3:0], patMem[base+5][3:0],
                           patMem[base+6][3:0], patMem[base+7], patMem[base+8][3:0]};
               checkValue(name, expected, actualCtrl);
            end
         end else begin
            assert (!seen)
            else begin
               $display("%s: decoded output appeared for a word that should be dropped", name);
               errors++;
            end
         end
         if (errors == errorsBefore) begin
            passed++;
            $display("%s ok", name);
         end else begin
            $display("%s did not match", name);
         end
         step++;
      end
      if (step == 0) begin
         $display("no test patterns were read");
         errors++;
      end
      $display("%0d tests run, %0d passed, %0d failed", step, passed, step - passed);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* testbench/decodePatterns.mem */
// each line holds group instr valid aluSel writeAddress cond op2 ctrlBits fwd in hex
// ctrlBits nibbles are we rw pc in / adr ar br ab / mw mad spc sw / spw inc dec flag / sex out halt 0
// fwd bits are oneA oneB twoA twoB
// groups run 0 decode, 1 fwd one, 2 fwd two, 3 squash, 4 halt, 5 reset first
0 CA00 1 0 2 2 1 4ED10 0 // add
0 EE50 1 1 6 6 5 0ED10 0 // cmp
0 FB60 1 C 3 3 7 4ED10 0 // mov
0 C5C0 1 C 5 5 0 52D00 0 // in
0 D6D0 1 D 6 6 2 02D04 0 // out
0 1C05 1 0 3 4 3 40D08 0 // ld
0 5110 1 0 1 1 2 83D08 0 // st
0 837F 1 C 3 3 0 48D08 0 // li
0 8E01 1 0 6 6 1 4AD18 0 // addi
0 AA00 1 1 2 2 5 40F08 0 // get
0 9C00 1 F 4 4 3 08F88 0 // set
0 9500 1 F 5 5 2 88948 0 // push
0 B100 1 1 1 1 6 80D08 0 // pop
1 D300 1 0 3 3 2 4ED10 0
1 C210 1 1 2 2 0 4ED10 8
1 CA20 1 2 2 2 1 4ED10 6
2 8C02 1 0 4 4 1 4AD18 0
2 8100 1 C 1 1 0 48D08 0
2 EC80 1 8 4 4 5 4AD10 1
2 8700 1 C 7 7 0 48D08 0
2 C540 1 4 5 5 0 4ED10 2
3 A010 1 0 0 0 4 28D08 0 // branch
3 C210 1 E 0 0 0 02D00 0
3 837F 1 E 0 0 0 02D00 0
3 CA00 1 0 2 2 1 4ED10 0
3 BA08 1 0 2 2 7 28D08 0 // conditional branch
3 C0F0 1 E 0 0 0 02D00 0
3 D300 1 E 0 0 0 02D00 0
4 C0F0 1 F 0 0 0 02D02 0
4 CA00 0 0 0 0 0 00000 0
5 DC10 1 1 4 4 3 4ED10 0

/* src.f */
+incdir+hw
hw/decodePkg.sv
hw/decodeCtrlIf.sv
hw/commandHistory.sv
hw/decodeUnit.sv
hw/squashTimer.sv
hw/issueControl.sv
hw/decodeStage.sv
testbench/decodeStageTb.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f src.f \
   --top-module decodeStageTb -o decodeStageSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/decodeStageSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0
